//--- include/sar_consts.svh
`ifndef SAR_CONSTS_SVH
`define SAR_CONSTS_SVH

// Buffer pool
`define SAR_NUM_BUFS          4
`define SAR_BUF_ID_WID        2

// Descriptor field widths
`define SAR_OFFSET_WID        8
`define SAR_SEG_LEN_WID       6
`define SAR_FRAME_LEN_WID     9

// Expiry, counted in ms ticks
`define SAR_TIMER_WID         4
`define SAR_EXPIRY_MS         10

// Queue depths and status counters
`define SAR_SEG_FIFO_DEPTH    4
`define SAR_FRAME_FIFO_DEPTH  2
`define SAR_CNT_WID           8

`endif

//--- source/sar_pkg.sv
`include "sar_consts.svh"

package sar_pkg;

    typedef logic [`SAR_BUF_ID_WID-1:0]    buf_id_t;
    typedef logic [`SAR_OFFSET_WID-1:0]    offset_t;
    typedef logic [`SAR_SEG_LEN_WID-1:0]   seg_len_t;
    typedef logic [`SAR_FRAME_LEN_WID-1:0] frame_len_t;
    typedef logic [`SAR_CNT_WID-1:0]       cnt_t;

    typedef struct packed {
        buf_id_t  buf_id;
        offset_t  offset;
        seg_len_t len;
        logic     last;
    } seg_t;

    typedef struct packed {
        buf_id_t    buf_id;
        frame_len_t len;
    } frame_t;

    // One contiguous fragment per buffer, end_off is one past the last byte
    typedef struct packed {
        logic       active;
        logic       last_seen;
        offset_t    start;
        frame_len_t end_off;
        frame_len_t total;
    } ctx_t;

endpackage

//--- source/sar_fifo.sv
`timescale 1ns/1ps

module sar_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 2
) (
    input  logic clk,
    input  logic arst_n,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     pop_data,
    output logic full,
    output logic empty
);

    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WID = $clog2(DEPTH + 1);

    typedef logic [PTR_WID-1:0] ptr_t;
    typedef logic [CNT_WID-1:0] count_t;

    T       mem [DEPTH];
    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    count_t count;
    logic   do_push;
    logic   do_pop;

    assign full    = (count == count_t'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Head of queue is always visible
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- source/sar_ctrl_fsm.sv
`timescale 1ns/1ps
`include "sar_consts.svh"

module sar_ctrl_fsm (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     en,
    input  logic [`SAR_NUM_BUFS-1:0] expired,
    output logic                     init_done,
    output logic                     clear_en,
    output sar_pkg::buf_id_t         clear_addr,
    output logic                     run,
    output logic                     expire_en,
    output sar_pkg::buf_id_t         expire_id
);

    localparam sar_pkg::buf_id_t LAST_ID = sar_pkg::buf_id_t'(`SAR_NUM_BUFS - 1);

    typedef enum logic [1:0] {
        ST_INIT,
        ST_RUN,
        ST_EXPIRE,
        ST_HALT
    } state_t;

    state_t           state;
    state_t           state_nxt;
    sar_pkg::buf_id_t addr;

    // ------------------------------------------------------------------------
    // State register and sweep address
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_INIT;
            addr  <= '0;
        end else begin
            state <= state_nxt;
            if (state == ST_INIT) begin
                addr <= addr + 1'b1;
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_INIT: begin
                if (addr == LAST_ID) begin
                    state_nxt = en ? ST_RUN : ST_HALT;
                end
            end
            ST_RUN: begin
                if (!en) begin
                    state_nxt = ST_HALT;
                end else if (|expired) begin
                    state_nxt = ST_EXPIRE;
                end
            end
            ST_EXPIRE: state_nxt = en ? ST_RUN : ST_HALT;
            default:   state_nxt = en ? ST_RUN : ST_HALT;
        endcase
    end

    // Lowest expired id wins
    always_comb begin
        expire_id = '0;
        for (int i = `SAR_NUM_BUFS - 1; i >= 0; i--) begin
            if (expired[i]) begin
                expire_id = sar_pkg::buf_id_t'(i);
            end
        end
    end

    assign init_done  = (state != ST_INIT);
    assign clear_en   = (state == ST_INIT);
    assign clear_addr = addr;
    assign run        = (state == ST_RUN) && en;
    // Buffer may have completed while the grant was pending
    assign expire_en  = (state == ST_EXPIRE) && (|expired);

endmodule

//--- source/sar_expiry_timer.sv
`timescale 1ns/1ps
`include "sar_consts.svh"

module sar_expiry_timer (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     run,
    input  logic                     ms_tick,
    input  logic                     alloc,
    input  sar_pkg::buf_id_t         alloc_id,
    input  logic                     free,
    input  sar_pkg::buf_id_t         free_id,
    output logic [`SAR_NUM_BUFS-1:0] expired
);

    typedef logic [`SAR_TIMER_WID-1:0] age_t;

    localparam age_t EXPIRY_AGE = age_t'(`SAR_EXPIRY_MS);
    localparam age_t AGE_MAX    = '1;

    logic [`SAR_NUM_BUFS-1:0] active;
    age_t                     age [`SAR_NUM_BUFS];

    // ------------------------------------------------------------------------
    // Per-buffer age tracking
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active <= '0;
            for (int i = 0; i < `SAR_NUM_BUFS; i++) begin
                age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `SAR_NUM_BUFS; i++) begin
                if (alloc && (alloc_id == sar_pkg::buf_id_t'(i))) begin
                    active[i] <= 1'b1;
                    age[i]    <= '0;
                end else if (free && (free_id == sar_pkg::buf_id_t'(i))) begin
                    active[i] <= 1'b0;
                end else if (run && ms_tick && active[i] && (age[i] != AGE_MAX)) begin
                    // Saturate so a stalled grant never wraps back to young
                    age[i] <= age[i] + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Expired vector
    // ------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < `SAR_NUM_BUFS; i++) begin
            expired[i] = active[i] && (age[i] >= EXPIRY_AGE);
        end
    end

endmodule

//--- source/sar_context_table.sv
`timescale 1ns/1ps
`include "sar_consts.svh"

module sar_context_table (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              clear_en,
    input  sar_pkg::buf_id_t  clear_addr,
    input  logic              run,
    input  logic              expire_en,
    input  sar_pkg::buf_id_t  expire_id,
    input  sar_pkg::seg_t     seg_head,
    input  logic              seg_avail,
    input  logic              frame_full,
    output logic              seg_pop,
    output logic              frame_push,
    output sar_pkg::frame_t   frame_data,
    output logic              alloc,
    output sar_pkg::buf_id_t  alloc_id,
    output logic              free,
    output sar_pkg::buf_id_t  free_id,
    output sar_pkg::cnt_t     drop_count,
    output sar_pkg::cnt_t     expire_count
);

    sar_pkg::ctx_t       ctx_mem [`SAR_NUM_BUFS];
    sar_pkg::ctx_t       ctx_cur;
    sar_pkg::ctx_t       ctx_new;
    sar_pkg::ctx_t       ctx_wr;
    sar_pkg::frame_len_t seg_start;
    sar_pkg::frame_len_t seg_end;
    logic                is_start;
    logic                is_append;
    logic                is_prepend;
    logic                conflict;
    logic                drop;
    logic                complete;
    logic                ctx_we;

    // ------------------------------------------------------------------------
    // Segment classification and merge
    // ------------------------------------------------------------------------
    always_comb begin
        ctx_cur    = ctx_mem[seg_head.buf_id];
        seg_start  = sar_pkg::frame_len_t'(seg_head.offset);
        seg_end    = seg_start + sar_pkg::frame_len_t'(seg_head.len);
        is_start   = !ctx_cur.active;
        is_append  = ctx_cur.active && (seg_start == ctx_cur.end_off);
        is_prepend = ctx_cur.active && (seg_end == sar_pkg::frame_len_t'(ctx_cur.start));

        ctx_new        = ctx_cur;
        ctx_new.active = 1'b1;
        if (is_start) begin
            ctx_new.last_seen = 1'b0;
            ctx_new.start     = seg_head.offset;
            ctx_new.end_off   = seg_end;
            ctx_new.total     = '0;
        end else if (is_prepend) begin
            ctx_new.start = seg_head.offset;
        end else if (is_append) begin
            ctx_new.end_off = seg_end;
        end
        // The last segment fixes the frame length
        if (seg_head.last) begin
            ctx_new.last_seen = 1'b1;
            ctx_new.total     = seg_end;
        end

        conflict = (seg_head.last && ctx_cur.active && ctx_cur.last_seen &&
                    (seg_end != ctx_cur.total)) ||
                   (ctx_new.last_seen && (ctx_new.end_off > ctx_new.total));
        drop     = (seg_head.len == '0) || !(is_start || is_append || is_prepend) ||
                   conflict;
        complete = !drop && ctx_new.last_seen && (ctx_new.start == '0) &&
                   (ctx_new.end_off == ctx_new.total);
        ctx_wr   = complete ? '0 : ctx_new;
    end

    // Completing segment waits at the head while the frame queue is full
    assign seg_pop    = run && seg_avail && !(complete && frame_full);
    assign frame_push = seg_pop && complete;
    assign ctx_we     = seg_pop && !drop;

    assign frame_data.buf_id = seg_head.buf_id;
    assign frame_data.len    = ctx_new.total;

    // Timer bookkeeping
    assign alloc    = ctx_we && is_start && !complete;
    assign alloc_id = seg_head.buf_id;
    assign free     = expire_en || frame_push;
    assign free_id  = expire_en ? expire_id : seg_head.buf_id;

    // ------------------------------------------------------------------------
    // Context storage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (clear_en) begin
            ctx_mem[clear_addr] <= '0;
        end else if (expire_en) begin
            ctx_mem[expire_id] <= '0;
        end else if (ctx_we) begin
            ctx_mem[seg_head.buf_id] <= ctx_wr;
        end
    end

    // Status counters
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            drop_count   <= '0;
            expire_count <= '0;
        end else begin
            if (seg_pop && drop) begin
                drop_count <= drop_count + 1'b1;
            end
            if (expire_en) begin
                expire_count <= expire_count + 1'b1;
            end
        end
    end

endmodule

//--- source/sar_reassembly.sv
`timescale 1ns/1ps
`include "sar_consts.svh"

module sar_reassembly (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                en,
    output logic                init_done,
    // Segment input
    input  logic                seg_valid,
    output logic                seg_ready,
    input  sar_pkg::buf_id_t    seg_buf_id,
    input  sar_pkg::offset_t    seg_offset,
    input  sar_pkg::seg_len_t   seg_len,
    input  logic                seg_last,
    input  logic                ms_tick,
    // Frame output
    input  logic                frame_ready,
    output logic                frame_valid,
    output sar_pkg::buf_id_t    frame_buf_id,
    output sar_pkg::frame_len_t frame_len,
    output sar_pkg::cnt_t       drop_count,
    output sar_pkg::cnt_t       expire_count
);

    sar_pkg::seg_t            seg_in;
    sar_pkg::seg_t            seg_head;
    logic                     seg_full;
    logic                     seg_empty;
    logic                     seg_pop;
    sar_pkg::frame_t          frame_data;
    sar_pkg::frame_t          frame_head;
    logic                     frame_push;
    logic                     frame_full;
    logic                     frame_empty;
    logic                     clear_en;
    sar_pkg::buf_id_t         clear_addr;
    logic                     run;
    logic                     expire_en;
    sar_pkg::buf_id_t         expire_id;
    logic [`SAR_NUM_BUFS-1:0] expired;
    logic                     alloc;
    sar_pkg::buf_id_t         alloc_id;
    logic                     free;
    sar_pkg::buf_id_t         free_id;

    // ------------------------------------------------------------------------
    // Segment queue
    // ------------------------------------------------------------------------
    assign seg_ready     = !seg_full && init_done;
    assign seg_in.buf_id = seg_buf_id;
    assign seg_in.offset = seg_offset;
    assign seg_in.len    = seg_len;
    assign seg_in.last   = seg_last;

    sar_fifo #(.T(sar_pkg::seg_t), .DEPTH(`SAR_SEG_FIFO_DEPTH)) seg_fifo_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (seg_valid && seg_ready),
        .push_data (seg_in),
        .pop       (seg_pop),
        .pop_data  (seg_head),
        .full      (seg_full),
        .empty     (seg_empty)
    );

    // ------------------------------------------------------------------------
    // Control, expiry and reassembly state
    // ------------------------------------------------------------------------
    sar_ctrl_fsm ctrl_fsm_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .en         (en),
        .expired    (expired),
        .init_done  (init_done),
        .clear_en   (clear_en),
        .clear_addr (clear_addr),
        .run        (run),
        .expire_en  (expire_en),
        .expire_id  (expire_id)
    );

    sar_expiry_timer expiry_timer_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .run      (run),
        .ms_tick  (ms_tick),
        .alloc    (alloc),
        .alloc_id (alloc_id),
        .free     (free),
        .free_id  (free_id),
        .expired  (expired)
    );

    sar_context_table context_table_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .clear_en     (clear_en),
        .clear_addr   (clear_addr),
        .run          (run),
        .expire_en    (expire_en),
        .expire_id    (expire_id),
        .seg_head     (seg_head),
        .seg_avail    (!seg_empty),
        .frame_full   (frame_full),
        .seg_pop      (seg_pop),
        .frame_push   (frame_push),
        .frame_data   (frame_data),
        .alloc        (alloc),
        .alloc_id     (alloc_id),
        .free         (free),
        .free_id      (free_id),
        .drop_count   (drop_count),
        .expire_count (expire_count)
    );

    // ------------------------------------------------------------------------
    // Frame queue
    // ------------------------------------------------------------------------
    sar_fifo #(.T(sar_pkg::frame_t), .DEPTH(`SAR_FRAME_FIFO_DEPTH)) frame_fifo_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (frame_push),
        .push_data (frame_data),
        .pop       (frame_valid && frame_ready),
        .pop_data  (frame_head),
        .full      (frame_full),
        .empty     (frame_empty)
    );

    assign frame_valid  = !frame_empty;
    assign frame_buf_id = frame_head.buf_id;
    assign frame_len    = frame_head.len;

endmodule

//--- dv/sar_reassembly_tb.sv
`timescale 1ns/1ps
`include "sar_consts.svh"

module sar_reassembly_tb;

    logic                clk;
    logic                arst_n;
    logic                en;
    logic                init_done;
    logic                seg_valid;
    logic                seg_ready;
    sar_pkg::buf_id_t    seg_buf_id;
    sar_pkg::offset_t    seg_offset;
    sar_pkg::seg_len_t   seg_len;
    logic                seg_last;
    logic                ms_tick;
    logic                frame_ready;
    logic                frame_valid;
    sar_pkg::buf_id_t    frame_buf_id;
    sar_pkg::frame_len_t frame_len;
    sar_pkg::cnt_t       drop_count;
    sar_pkg::cnt_t       expire_count;

    // Parsed pattern file, one entry per command
    logic [7:0]          op_q [$];
    int                  a_q [$];
    int                  b_q [$];
    int                  c_q [$];
    int                  d_q [$];
    logic [8*16-1:0]     name_q [$];

    sar_pkg::frame_t     exp_q [$];
    sar_pkg::frame_t     mon_frame;
    sar_pkg::frame_t     mon_exp;
    logic                rand_ready;
    logic [15:0]         lfsr;
    int                  cycle_limit;
    int                  err_total;
    int                  test_errs;
    int                  tests_passed;
    int                  tests_failed;

    sar_reassembly dut_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .en           (en),
        .init_done    (init_done),
        .seg_valid    (seg_valid),
        .seg_ready    (seg_ready),
        .seg_buf_id   (seg_buf_id),
        .seg_offset   (seg_offset),
        .seg_len      (seg_len),
        .seg_last     (seg_last),
        .ms_tick      (ms_tick),
        .frame_ready  (frame_ready),
        .frame_valid  (frame_valid),
        .frame_buf_id (frame_buf_id),
        .frame_len    (frame_len),
        .drop_count   (drop_count),
        .expire_count (expire_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic count_error();
        err_total++;
        test_errs++;
    endtask

    task automatic check_frame(input sar_pkg::frame_t got, input sar_pkg::frame_t exp);
        if (got !== exp) begin
            $display("[ERROR] %t frame_buf_id/frame_len: got %0d/%0d, expected %0d/%0d",
                     $time, got.buf_id, got.len, exp.buf_id, exp.len);
            count_error();
        end
    endtask

    task automatic check_count(input string name, input sar_pkg::cnt_t got,
                               input sar_pkg::cnt_t exp);
        if (got !== exp) begin
            $display("[ERROR] %t %s: got %0d, expected %0d", $time, name, got, exp);
            count_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %t %s: got %b, expected %b", $time, name, got, exp);
            count_error();
        end
    endtask

    // ------------------------------------------------------------------------
    // Pattern file
    // ------------------------------------------------------------------------
    task automatic load_patterns();
        int               fd;
        int               n;
        int               a;
        int               b;
        int               c;
        int               d;
        int               extra;
        logic             keep;
        logic [7:0]       cmd;
        logic [8*16-1:0]  name;
        logic [8*160-1:0] junk;
        fd = $fopen("dv/sar_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/sar_patterns.txt, run from the project root");
            count_error();
        end else begin
            extra = 0;
            while ($fscanf(fd, "%s", cmd) == 1) begin
                a = 0;
                b = 0;
                c = 0;
                d = 0;
                name = '0;
                keep = 1'b1;
                case (cmd)
                    "#": begin
                        n = $fgets(junk, fd);
                        keep = 1'b0;
                    end
                    "S": n = $fscanf(fd, "%d %d %d %d", a, b, c, d);
                    "F", "C": n = $fscanf(fd, "%d %d", a, b);
                    "T", "W", "X", "R": n = $fscanf(fd, "%d", a);
                    "P": n = $fscanf(fd, "%s", name);
                    default: begin
                        $display("unknown command %s in the pattern file", cmd);
                        n = $fgets(junk, fd);
                        keep = 1'b0;
                        count_error();
                    end
                endcase
                // Each tick pulse takes two cycles
                if (cmd == "T") begin
                    extra += 2 * a;
                end else if (cmd == "W") begin
                    extra += a;
                end
                if (keep) begin
                    op_q.push_back(cmd);
                    a_q.push_back(a);
                    b_q.push_back(b);
                    c_q.push_back(c);
                    d_q.push_back(d);
                    name_q.push_back(name);
                end
            end
            $fclose(fd);
            cycle_limit = op_q.size() * 64 + extra;
        end
    endtask

    // ------------------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------------------
    task automatic send_segment(input int b, input int off, input int len, input int last);
        @(posedge clk);
        seg_valid  <= 1'b1;
        seg_buf_id <= sar_pkg::buf_id_t'(b);
        seg_offset <= sar_pkg::offset_t'(off);
        seg_len    <= sar_pkg::seg_len_t'(len);
        seg_last   <= (last != 0);
        @(negedge clk);
        while (!seg_ready) begin
            @(negedge clk);
        end
        // Transfer happens on this edge
        @(posedge clk);
        seg_valid <= 1'b0;
    endtask

    task automatic send_ticks(input int count);
        repeat (count) begin
            @(posedge clk);
            ms_tick <= 1'b1;
            @(posedge clk);
            ms_tick <= 1'b0;
        end
    endtask

    task automatic expect_frame(input int b, input int len);
        sar_pkg::frame_t f;
        f.buf_id = sar_pkg::buf_id_t'(b);
        f.len    = sar_pkg::frame_len_t'(len);
        exp_q.push_back(f);
    endtask

    // Counters settle a few cycles after the last segment or tick, then must hold
    task automatic poll_counts(input int exp_drop, input int exp_expire);
        int            polls;
        int            held;
        sar_pkg::cnt_t want_drop;
        sar_pkg::cnt_t want_expire;
        want_drop   = sar_pkg::cnt_t'(exp_drop);
        want_expire = sar_pkg::cnt_t'(exp_expire);
        polls = 0;
        held  = 0;
        @(negedge clk);
        while ((drop_count != want_drop || expire_count != want_expire) && polls < 32) begin
            @(negedge clk);
            polls++;
        end
        // A late increment shows up within a few cycles
        while (held < 8 && drop_count == want_drop && expire_count == want_expire) begin
            @(negedge clk);
            held++;
        end
        check_count("drop_count", drop_count, want_drop);
        check_count("expire_count", expire_count, want_expire);
    endtask

    task automatic finish_test(input logic [8*16-1:0] name);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        if (test_errs == 0) begin
            $display("test %0s passed", name);
            tests_passed++;
        end else begin
            $display("test %0s failed with %0d errors", name, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    // ------------------------------------------------------------------------
    // Frame port: ready source and monitor
    // ------------------------------------------------------------------------
    initial begin
        frame_ready = 1'b1;
        lfsr = 16'd17554;
        forever begin
            @(posedge clk);
            if (rand_ready) begin
                frame_ready <= lfsr[0];
                lfsr = lfsr_next(lfsr);
            end else begin
                frame_ready <= 1'b1;
            end
        end
    end

    always @(negedge clk) begin
        if (arst_n && frame_valid && frame_ready) begin
            mon_frame.buf_id = frame_buf_id;
            mon_frame.len    = frame_len;
            if (exp_q.size() == 0) begin
                $display("unexpected frame at %t from buffer %0d with length %0d",
                         $time, frame_buf_id, frame_len);
                count_error();
            end else begin
                mon_exp = exp_q.pop_front();
                check_frame(mon_frame, mon_exp);
            end
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        $timeformat(-9, 1, " ns", 0);
        arst_n     = 1'b0;
        en         = 1'b1;
        seg_valid  = 1'b0;
        seg_buf_id = '0;
        seg_offset = '0;
        seg_len    = '0;
        seg_last   = 1'b0;
        ms_tick    = 1'b0;
        rand_ready = 1'b0;
        load_patterns();

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_flag("init_done", init_done, 1'b0);
        check_flag("seg_ready", seg_ready, 1'b0);
        check_flag("frame_valid", frame_valid, 1'b0);
        check_count("drop_count", drop_count, '0);
        check_count("expire_count", expire_count, '0);
        @(posedge clk);
        arst_n <= 1'b1;

        // Sweep covers every buffer, then init_done on the next cycle
        repeat (`SAR_NUM_BUFS) begin
            @(negedge clk);
            check_flag("init_done", init_done, 1'b0);
        end
        @(negedge clk);
        check_flag("init_done", init_done, 1'b1);

        for (int i = 0; i < op_q.size(); i++) begin
            case (op_q[i])
                "S": send_segment(a_q[i], b_q[i], c_q[i], d_q[i]);
                "T": send_ticks(a_q[i]);
                "W": repeat (a_q[i]) @(posedge clk);
                "X": begin
                    @(posedge clk);
                    en <= (a_q[i] != 0);
                end
                "R": begin
                    @(posedge clk);
                    rand_ready <= (a_q[i] != 0);
                end
                "F": expect_frame(a_q[i], b_q[i]);
                "C": poll_counts(a_q[i], b_q[i]);
                default: finish_test(name_q[i]);
            endcase
        end

        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, err_total);
        if (err_total == 0 && tests_failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
source/sar_pkg.sv
source/sar_fifo.sv
source/sar_ctrl_fsm.sv
source/sar_expiry_timer.sv
source/sar_context_table.sv
source/sar_reassembly.sv
dv/sar_reassembly_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f flist.f --top-module sar_reassembly_tb \
		--Mdir obj_dir -o sar_sim
	./obj_dir/sar_sim | tee sim.log
	grep -qx "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/sar_patterns.txt
# Commands: S buf off len last | T ticks | W cycles | X en | R random frame_ready
# F buf len = expected frame | C drop expire = expected counts | P name = end of test
F 0 48
S 0 0 16 0
S 0 16 16 0
S 0 32 16 1
C 0 0
P in_order
F 1 48
S 1 32 16 1
S 1 16 16 0
S 1 0 16 0
C 0 0
P out_of_order
F 2 24
F 1 30
F 0 16
F 3 60
S 0 0 8 0
S 1 20 10 1
S 2 0 12 0
S 3 40 20 1
S 2 12 12 1
S 1 0 20 0
S 0 8 8 1
S 3 0 40 0
C 0 0
P interleave
# overlap, gap, zero length, then a last that conflicts with the known total
F 0 32
F 1 32
S 0 0 16 0
S 0 8 16 0
S 0 24 8 0
S 0 16 0 0
S 0 16 16 1
S 1 16 16 1
S 1 0 16 1
S 1 0 16 0
C 4 0
P drops
S 2 0 16 0
W 2
T 9
C 4 0
T 1
C 4 1
F 2 20
S 2 0 20 1
C 4 1
P expiry
# ticks while disabled must not age buffer 1
R 1
F 0 24
F 1 40
F 2 16
F 3 30
F 0 10
F 1 12
F 2 4
F 3 4
F 0 4
F 1 4
S 0 0 24 1
S 1 0 20 0
X 0
S 1 20 20 1
S 2 8 8 1
S 2 0 8 0
T 12
W 6
X 1
S 3 0 30 1
S 0 0 5 0
S 0 5 5 1
S 1 0 6 0
S 1 6 6 1
S 2 0 4 1
S 3 0 4 1
S 0 0 4 1
S 1 0 4 1
C 4 1
R 0
P backpressure
